/* rtl/cache_array.sv */
/*
 direct-mapped cache array
 holds tag, valid, dirty and line storage for one port. the lookup
 result and the victim of the indexed set are registered one cycle
 after the address. word writes are byte-masked and mark the line
 dirty, a refill replaces the whole line and marks it clean
 */
module cache_array #(
    parameter int SETS = mem_cfg_pkg::default_sets
) (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_cfg_pkg::addr_t    lookup_addr,
    input  logic                  word_we,
    input  mem_access_pkg::size_t word_size,
    input  mem_cfg_pkg::word_t    word_wdata,
    input  logic                  refill_we,
    input  mem_cfg_pkg::line_t    refill_line,
    output logic                  hit,
    output logic                  victim_dirty,
    output mem_cfg_pkg::addr_t    victim_addr,
    output mem_cfg_pkg::line_t    victim_line,
    output mem_cfg_pkg::word_t    rdata
);

    localparam int off_w = $clog2(mem_cfg_pkg::line_bytes);
    localparam int idx_w = $clog2(SETS);
    localparam int tag_w = mem_cfg_pkg::addr_w - idx_w - off_w;
    localparam int wsel_w = $clog2(mem_cfg_pkg::line_words);
    localparam int lanes = mem_cfg_pkg::word_bytes;

    logic [tag_w-1:0]   tag_mem [SETS];
    mem_cfg_pkg::line_t line_mem [SETS];
    logic [SETS-1:0]    valid;
    logic [SETS-1:0]    dirty;

    // line from the off-chip response, held for the refill cycle
    mem_cfg_pkg::line_t line_q;

    logic [idx_w-1:0]   idx;
    logic [tag_w-1:0]   tag;
    logic [wsel_w-1:0]  wsel;
    logic [lanes-1:0]   mask;
    mem_cfg_pkg::word_t lane_data;

    assign idx  = lookup_addr[off_w +: idx_w];
    assign tag  = lookup_addr[mem_cfg_pkg::addr_w-1 -: tag_w];
    assign wsel = lookup_addr[off_w-1:2];

    // byte and halfword values sit in the low bits of word_wdata
    // and are replicated onto every lane, the mask picks the lane
    always_comb begin
        case (word_size)
            mem_access_pkg::size_byte: begin
                mask      = 4'b0001 << lookup_addr[1:0];
                lane_data = {4{word_wdata[7:0]}};
            end
            mem_access_pkg::size_half: begin
                mask      = 4'b0011 << {lookup_addr[1], 1'b0};
                lane_data = {2{word_wdata[15:0]}};
            end
            default: begin
                mask      = 4'b1111;
                lane_data = word_wdata;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            valid        <= '0;
            dirty        <= '0;
            hit          <= 1'b0;
            victim_dirty <= 1'b0;
        end else begin
            hit          <= valid[idx] && (tag_mem[idx] == tag);
            victim_dirty <= valid[idx] && dirty[idx];
            if (refill_we) begin
                valid[idx] <= 1'b1;
                dirty[idx] <= 1'b0;
            end else if (word_we) begin
                dirty[idx] <= 1'b1;
            end
        end
    end

    // storage and registered read-out
    always_ff @(posedge clk) begin
        line_q      <= refill_line;
        victim_addr <= {tag_mem[idx], idx, {off_w{1'b0}}};
        victim_line <= line_mem[idx];
        rdata       <= line_mem[idx][wsel*mem_cfg_pkg::word_w +: mem_cfg_pkg::word_w];
        if (refill_we) begin
            tag_mem[idx]  <= tag;
            line_mem[idx] <= line_q;
        end else if (word_we) begin
            for (int b = 0; b < lanes; b++) begin
                if (mask[b]) begin
                    line_mem[idx][wsel*mem_cfg_pkg::word_w + b*8 +: 8] <= lane_data[b*8 +: 8];
                end
            end
        end
    end

    a_one_write: assert property (@(posedge clk) disable iff (rst)
        !(refill_we && word_we));

    // the controller only writes a word once the lookup has hit
    a_write_on_hit: assert property (@(posedge clk) disable iff (rst)
        word_we |-> hit);

endmodule

/* rtl/cache_port_ctrl.sv */
/*
 per-port cache controller
 turns a registered array lookup into ready on a hit. on a miss it
 writes back a dirty victim, fetches the line off-chip and refills
 the array, then repeats the lookup
 */
module cache_port_ctrl #(
    parameter int SETS     = mem_cfg_pkg::default_sets,
    parameter bit WRITABLE = 1'b0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  logic               req_write,
    output logic               req_ready,
    input  mem_cfg_pkg::addr_t req_addr,
    output logic               line_req_valid,
    input  logic               line_req_ready,
    output logic               line_req_write,
    output mem_cfg_pkg::addr_t line_req_addr,
    input  logic               line_resp_valid,
    input  logic               array_hit,
    input  logic               array_victim_dirty,
    input  mem_cfg_pkg::addr_t array_victim_addr,
    output logic               word_we,
    output logic               refill_we
);

    localparam int off_w = $clog2(mem_cfg_pkg::line_bytes);
    localparam int idx_w = $clog2(SETS);

    mem_access_pkg::fill_state_t state;

    // array output belongs to the current request
    logic looked;
    // fetch accepted, waiting for the line
    logic sent;

    logic lookup_done;
    logic miss;
    logic victim_wb;
    mem_cfg_pkg::addr_t fetch_addr;

    assign lookup_done = (state == mem_access_pkg::fill_idle) && looked && req_valid;
    assign req_ready   = lookup_done && array_hit;
    assign miss        = lookup_done && !array_hit;

    // read-only ports never see dirty lines nor write words
    assign victim_wb = WRITABLE && array_victim_dirty;
    assign word_we   = WRITABLE && req_ready && req_write;

    assign refill_we = (state == mem_access_pkg::fill_refill);

    assign fetch_addr = {req_addr[mem_cfg_pkg::addr_w-1:off_w], {off_w{1'b0}}};

    assign line_req_valid = ((state == mem_access_pkg::fill_writeback) ||
                             (state == mem_access_pkg::fill_fetch)) && !sent;
    assign line_req_write = (state == mem_access_pkg::fill_writeback);
    assign line_req_addr  = line_req_write ? array_victim_addr : fetch_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= mem_access_pkg::fill_idle;
            looked <= 1'b0;
            sent   <= 1'b0;
        end else begin
            // a completed access or a refill forces a fresh lookup
            looked <= (state == mem_access_pkg::fill_idle) && req_valid &&
                      !req_ready && !miss;
            case (state)
                mem_access_pkg::fill_idle: begin
                    if (miss) begin
                        state <= victim_wb ? mem_access_pkg::fill_writeback
                                           : mem_access_pkg::fill_fetch;
                    end
                end
                mem_access_pkg::fill_writeback: begin
                    // write is done once accepted
                    if (line_req_ready) begin
                        state <= mem_access_pkg::fill_fetch;
                    end
                end
                mem_access_pkg::fill_fetch: begin
                    if (line_resp_valid) begin
                        state <= mem_access_pkg::fill_refill;
                        sent  <= 1'b0;
                    end else if (line_req_ready && !sent) begin
                        sent <= 1'b1;
                    end
                end
                mem_access_pkg::fill_refill: begin
                    state <= mem_access_pkg::fill_idle;
                end
                default: begin
                    state <= mem_access_pkg::fill_idle;
                end
            endcase
        end
    end

    // ready ends a lookup that started in idle with the request up
    a_ready_in_idle: assert property (@(posedge clk) disable iff (rst)
        req_ready |-> $past((state == mem_access_pkg::fill_idle) && req_valid));

    // victim read back from the array must sit in the requested set
    a_victim_set: assert property (@(posedge clk) disable iff (rst)
        (state == mem_access_pkg::fill_writeback) |->
        array_victim_addr[off_w +: idx_w] == req_addr[off_w +: idx_w]);

endmodule

/* rtl/mem_access_pkg.sv */
/*
 access encodings
 processor access-size codes and the state type of the per-port
 miss controller
 */
package mem_access_pkg;

    // access size on the data port
    typedef logic [1:0] size_t;

    localparam size_t size_word = 2'd0;
    localparam size_t size_byte = 2'd1;
    localparam size_t size_half = 2'd2;

    // miss handling sequence
    typedef enum logic [1:0] {
        fill_idle      = 2'd0,
        fill_writeback = 2'd1,
        fill_fetch     = 2'd2,
        fill_refill    = 2'd3
    } fill_state_t;

endpackage

/* rtl/mem_cfg_pkg.sv */
/*
 memory subsystem geometry
 address, word and line widths shared by the caches, the port
 controllers and the off-chip interface, plus the default cache depth
 */
package mem_cfg_pkg;

    // processor side
    localparam int addr_w = 32;
    localparam int word_w = 32;
    localparam int word_bytes = word_w / 8;

    // one cache line, also the off-chip transfer unit
    localparam int line_bytes = 16;
    localparam int line_w = line_bytes * 8;
    localparam int line_words = line_bytes / word_bytes;

    // direct-mapped depth unless the top level overrides it
    localparam int default_sets = 64;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [word_w-1:0] word_t;
    typedef logic [line_w-1:0] line_t;

endpackage

/* rtl/mem_controller.sv */
/*
 memory subsystem top
 instruction and data caches with their port controllers sharing
 one off-chip line interface through the arbiter
 */
module mem_controller #(
    parameter int SETS = mem_cfg_pkg::default_sets
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid,
    output logic                  inst_ready,
    input  mem_cfg_pkg::addr_t    inst_addr,
    output mem_cfg_pkg::word_t    inst_rdata,
    input  logic                  data_valid,
    output logic                  data_ready,
    input  logic                  data_write,
    input  mem_access_pkg::size_t data_size,
    input  mem_cfg_pkg::addr_t    data_addr,
    input  mem_cfg_pkg::word_t    data_wdata,
    output mem_cfg_pkg::word_t    data_rdata,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output logic                  mem_req_write,
    output mem_cfg_pkg::addr_t    mem_req_addr,
    output mem_cfg_pkg::line_t    mem_req_wdata,
    input  logic                  mem_resp_valid,
    input  mem_cfg_pkg::line_t    mem_resp_rdata
);

    // instruction side
    logic               i_hit;
    logic               i_victim_dirty;
    mem_cfg_pkg::addr_t i_victim_addr;
    logic               i_word_we;
    logic               i_refill_we;
    logic               i_line_req_valid;
    logic               i_line_req_ready;
    logic               i_line_req_write;
    mem_cfg_pkg::addr_t i_line_req_addr;
    logic               i_line_resp_valid;
    mem_cfg_pkg::line_t i_line_resp_rdata;

    // data side
    logic               d_hit;
    logic               d_victim_dirty;
    mem_cfg_pkg::addr_t d_victim_addr;
    mem_cfg_pkg::line_t d_victim_line;
    logic               d_word_we;
    logic               d_refill_we;
    logic               d_line_req_valid;
    logic               d_line_req_ready;
    logic               d_line_req_write;
    mem_cfg_pkg::addr_t d_line_req_addr;
    logic               d_line_resp_valid;
    mem_cfg_pkg::line_t d_line_resp_rdata;

    cache_array #(.SETS(SETS)) i_array (
        .clk(clk), .rst(rst),
        .lookup_addr(inst_addr),
        .word_we(i_word_we), .word_size(mem_access_pkg::size_word), .word_wdata('0),
        .refill_we(i_refill_we), .refill_line(i_line_resp_rdata),
        .hit(i_hit), .victim_dirty(i_victim_dirty), .victim_addr(i_victim_addr),
        .victim_line(), .rdata(inst_rdata)
    );

    cache_port_ctrl #(.SETS(SETS), .WRITABLE(1'b0)) i_ctrl (
        .clk(clk), .rst(rst),
        .req_valid(inst_valid), .req_write(1'b0), .req_ready(inst_ready),
        .req_addr(inst_addr),
        .line_req_valid(i_line_req_valid), .line_req_ready(i_line_req_ready),
        .line_req_write(i_line_req_write), .line_req_addr(i_line_req_addr),
        .line_resp_valid(i_line_resp_valid),
        .array_hit(i_hit), .array_victim_dirty(i_victim_dirty),
        .array_victim_addr(i_victim_addr),
        .word_we(i_word_we), .refill_we(i_refill_we)
    );

    cache_array #(.SETS(SETS)) d_array (
        .clk(clk), .rst(rst),
        .lookup_addr(data_addr),
        .word_we(d_word_we), .word_size(data_size), .word_wdata(data_wdata),
        .refill_we(d_refill_we), .refill_line(d_line_resp_rdata),
        .hit(d_hit), .victim_dirty(d_victim_dirty), .victim_addr(d_victim_addr),
        .victim_line(d_victim_line), .rdata(data_rdata)
    );

    cache_port_ctrl #(.SETS(SETS), .WRITABLE(1'b1)) d_ctrl (
        .clk(clk), .rst(rst),
        .req_valid(data_valid), .req_write(data_write), .req_ready(data_ready),
        .req_addr(data_addr),
        .line_req_valid(d_line_req_valid), .line_req_ready(d_line_req_ready),
        .line_req_write(d_line_req_write), .line_req_addr(d_line_req_addr),
        .line_resp_valid(d_line_resp_valid),
        .array_hit(d_hit), .array_victim_dirty(d_victim_dirty),
        .array_victim_addr(d_victim_addr),
        .word_we(d_word_we), .refill_we(d_refill_we)
    );

    offchip_arbiter arb (
        .clk(clk), .rst(rst),
        .inst_req_valid(i_line_req_valid), .inst_req_ready(i_line_req_ready),
        .inst_req_write(i_line_req_write), .inst_req_addr(i_line_req_addr),
        .inst_resp_valid(i_line_resp_valid), .inst_resp_rdata(i_line_resp_rdata),
        .data_req_valid(d_line_req_valid), .data_req_ready(d_line_req_ready),
        .data_req_write(d_line_req_write), .data_req_addr(d_line_req_addr),
        .data_req_wdata(d_victim_line),
        .data_resp_valid(d_line_resp_valid), .data_resp_rdata(d_line_resp_rdata),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req_write(mem_req_write), .mem_req_addr(mem_req_addr),
        .mem_req_wdata(mem_req_wdata),
        .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata)
    );

endmodule

/* rtl/offchip_arbiter.sv */
/*
 off-chip line interface arbiter
 grants the single memory interface to one port controller at a
 time, data port first. the grant holds through acceptance of a
 write or until the response of a read
 */
module offchip_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_req_valid,
    output logic               inst_req_ready,
    input  logic               inst_req_write,
    input  mem_cfg_pkg::addr_t inst_req_addr,
    output logic               inst_resp_valid,
    output mem_cfg_pkg::line_t inst_resp_rdata,
    input  logic               data_req_valid,
    output logic               data_req_ready,
    input  logic               data_req_write,
    input  mem_cfg_pkg::addr_t data_req_addr,
    input  mem_cfg_pkg::line_t data_req_wdata,
    output logic               data_resp_valid,
    output mem_cfg_pkg::line_t data_resp_rdata,
    output logic               mem_req_valid,
    input  logic               mem_req_ready,
    output logic               mem_req_write,
    output mem_cfg_pkg::addr_t mem_req_addr,
    output mem_cfg_pkg::line_t mem_req_wdata,
    input  logic               mem_resp_valid,
    input  mem_cfg_pkg::line_t mem_resp_rdata
);

    logic held;
    logic held_data;
    logic sel_data;
    logic active;
    logic done;

    // idle picks the data port on a tie, otherwise keep the owner
    assign sel_data = held ? held_data : data_req_valid;
    assign active   = held || inst_req_valid || data_req_valid;

    assign mem_req_valid = sel_data ? data_req_valid : inst_req_valid;
    assign mem_req_write = sel_data ? data_req_write : inst_req_write;
    assign mem_req_addr  = sel_data ? data_req_addr : inst_req_addr;
    // only the data cache ever writes a line back
    assign mem_req_wdata = data_req_wdata;

    assign inst_req_ready  = !sel_data && mem_req_ready;
    assign data_req_ready  = sel_data && mem_req_ready;
    assign inst_resp_valid = !sel_data && mem_resp_valid;
    assign data_resp_valid = sel_data && mem_resp_valid;
    assign inst_resp_rdata = mem_resp_rdata;
    assign data_resp_rdata = mem_resp_rdata;

    assign done = (mem_req_valid && mem_req_ready && mem_req_write) || mem_resp_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            held      <= 1'b0;
            held_data <= 1'b0;
        end else begin
            held      <= active && !done;
            held_data <= sel_data;
        end
    end

    // a port left waiting keeps asking until it is served
    a_inst_waits: assert property (@(posedge clk) disable iff (rst)
        inst_req_valid && !inst_req_ready |=> inst_req_valid);

    a_data_waits: assert property (@(posedge clk) disable iff (rst)
        data_req_valid && !data_req_ready |=> data_req_valid);

    // memory answers only a read that this arbiter passed on
    a_resp_granted: assert property (@(posedge clk) disable iff (rst)
        mem_resp_valid |-> held && !mem_req_valid);

endmodule

/* src.f */
rtl/mem_cfg_pkg.sv
rtl/mem_access_pkg.sv
rtl/cache_array.sv
rtl/cache_port_ctrl.sv
rtl/offchip_arbiter.sv
rtl/mem_controller.sv
tests/offchip_mem_model.sv
tests/tb_mem_controller.sv

/* tests/offchip_mem_model.sv */
/*
 off-chip memory responder
 accepts line requests from the memory subsystem. reads answer after a
 random delay with either a line written back earlier or the address
 hash pattern, writes complete at acceptance
 */
module offchip_mem_model #(
    parameter int SLOTS = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_req_valid,
    output logic               mem_req_ready,
    input  logic               mem_req_write,
    input  mem_cfg_pkg::addr_t mem_req_addr,
    input  mem_cfg_pkg::line_t mem_req_wdata,
    output logic               mem_resp_valid,
    output mem_cfg_pkg::line_t mem_resp_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    // lines written back, everything else reads as the pattern
    mem_cfg_pkg::addr_t slot_addr [SLOTS];
    mem_cfg_pkg::line_t slot_line [SLOTS];
    logic [SLOTS-1:0]   slot_used = '0;

    logic               busy = 1'b0;
    int                 wait_cnt = 0;
    mem_cfg_pkg::addr_t rd_addr = '0;

    initial begin
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
    end

    // one read outstanding at a time
    assign mem_req_ready = !busy;

    function automatic mem_cfg_pkg::word_t pattern_word(input mem_cfg_pkg::addr_t a);
        mem_cfg_pkg::word_t h;
        h = a * 32'h9e37_79b1;
        return h ^ (h >> 15) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic mem_cfg_pkg::line_t read_line(input mem_cfg_pkg::addr_t a);
        mem_cfg_pkg::line_t l;
        for (int w = 0; w < mem_cfg_pkg::line_words; w++) begin
            l[w*mem_cfg_pkg::word_w +: mem_cfg_pkg::word_w] = pattern_word(a + 4 * w);
        end
        for (int s = 0; s < SLOTS; s++) begin
            if (slot_used[s] && slot_addr[s] == a) begin
                l = slot_line[s];
            end
        end
        return l;
    endfunction

    task automatic store_line(input mem_cfg_pkg::addr_t a, input mem_cfg_pkg::line_t l);
        int pick;
        pick = -1;
        for (int s = SLOTS - 1; s >= 0; s--) begin
            if (!slot_used[s]) begin
                pick = s;
            end
        end
        // an existing copy of the line is overwritten in place
        for (int s = 0; s < SLOTS; s++) begin
            if (slot_used[s] && slot_addr[s] == a) begin
                pick = s;
            end
        end
        if (pick >= 0) begin
            slot_used[pick] = 1'b1;
            slot_addr[pick] = a;
            slot_line[pick] = l;
        end
    endtask

    // sample at the edge, answer shortly after it
    always @(posedge clk) begin : serve
        logic               take;
        logic               wr;
        mem_cfg_pkg::addr_t addr;
        mem_cfg_pkg::line_t wdata;
        take  = mem_req_valid && mem_req_ready;
        wr    = mem_req_write;
        addr  = mem_req_addr;
        wdata = mem_req_wdata;
        #1;
        if (rst) begin
            busy           = 1'b0;
            mem_resp_valid = 1'b0;
        end else begin
            mem_resp_valid = 1'b0;
            if (busy && wait_cnt == 0) begin
                mem_resp_valid = 1'b1;
                mem_resp_rdata = read_line(rd_addr);
                busy           = 1'b0;
            end else if (busy) begin
                wait_cnt = wait_cnt - 1;
            end
            if (take && wr) begin
                store_line(addr, wdata);
            end else if (take) begin
                busy     = 1'b1;
                rd_addr  = addr;
                wait_cnt = int'($urandom_range(7, 0));
            end
        end
    end

endmodule

/* tests/tb_mem_controller.sv */
/*
 memory subsystem testbench
 runs random instruction reads and data reads and writes on both ports
 at once against a word-level reference model, and watches the
 off-chip interface for aligned addresses and correct writebacks
 */
module tb_mem_controller;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ops_per_port  = 400;
    localparam int cycles_per_op = 40;
    localparam int max_cycles    = 2 * ops_per_port * cycles_per_op;

    localparam int sets      = mem_cfg_pkg::default_sets;
    localparam int set_shift = $clog2(mem_cfg_pkg::line_bytes);
    localparam int tag_shift = set_shift + $clog2(sets);

    // 4 tags by 4 sets by 4 words in each region
    localparam int data_words = 64;
    localparam int data_lines = data_words / mem_cfg_pkg::line_words;
    localparam mem_cfg_pkg::addr_t inst_base = 32'h0000_1000;
    localparam mem_cfg_pkg::addr_t data_base = 32'h8000_0000;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  inst_valid;
    logic                  inst_ready;
    mem_cfg_pkg::addr_t    inst_addr;
    mem_cfg_pkg::word_t    inst_rdata;
    logic                  data_valid;
    logic                  data_ready;
    logic                  data_write;
    mem_access_pkg::size_t data_size;
    mem_cfg_pkg::addr_t    data_addr;
    mem_cfg_pkg::word_t    data_wdata;
    mem_cfg_pkg::word_t    data_rdata;
    logic                  mem_req_valid;
    logic                  mem_req_ready;
    logic                  mem_req_write;
    mem_cfg_pkg::addr_t    mem_req_addr;
    mem_cfg_pkg::line_t    mem_req_wdata;
    logic                  mem_resp_valid;
    mem_cfg_pkg::line_t    mem_resp_rdata;

    mem_cfg_pkg::word_t    ref_mem [data_words];
    logic [data_lines-1:0] line_written;
    int                    writebacks = 0;
    int                    cycles = 0;

    mem_controller #(.SETS(sets)) uut (
        .clk(clk), .rst(rst),
        .inst_valid(inst_valid), .inst_ready(inst_ready),
        .inst_addr(inst_addr), .inst_rdata(inst_rdata),
        .data_valid(data_valid), .data_ready(data_ready), .data_write(data_write),
        .data_size(data_size), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_rdata(data_rdata),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req_write(mem_req_write), .mem_req_addr(mem_req_addr),
        .mem_req_wdata(mem_req_wdata),
        .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata)
    );

    offchip_mem_model mem (
        .clk(clk), .rst(rst),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req_write(mem_req_write), .mem_req_addr(mem_req_addr),
        .mem_req_wdata(mem_req_wdata),
        .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input mem_cfg_pkg::word_t got, input mem_cfg_pkg::word_t exp,
                              input string name);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input mem_cfg_pkg::addr_t got, input mem_cfg_pkg::addr_t exp,
                              input string name);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // initial contents of every off-chip word
    function automatic mem_cfg_pkg::word_t pattern_word(input mem_cfg_pkg::addr_t a);
        mem_cfg_pkg::word_t h;
        h = a * 32'h9e37_79b1;
        return h ^ (h >> 15) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic mem_cfg_pkg::addr_t data_word_addr(input int i);
        return data_base | mem_cfg_pkg::addr_t'((((i >> 4) & 3) << tag_shift) |
                                                (((i >> 2) & 3) << set_shift) |
                                                ((i & 3) << 2));
    endfunction

    // byte lanes picked by size code and low address bits
    function automatic mem_cfg_pkg::word_t merge_write(input mem_cfg_pkg::word_t old,
                                                       input mem_cfg_pkg::word_t wdata,
                                                       input mem_access_pkg::size_t size,
                                                       input logic [1:0] off);
        mem_cfg_pkg::word_t w;
        w = old;
        case (size)
            mem_access_pkg::size_byte: w[off*8 +: 8] = wdata[7:0];
            mem_access_pkg::size_half: w[off[1]*16 +: 16] = wdata[15:0];
            default: w = wdata;
        endcase
        return w;
    endfunction

    task automatic check_writeback();
        int l;
        l = int'(mem_req_addr[tag_shift +: 2]) * 4 + int'(mem_req_addr[set_shift +: 2]);
        check_addr(mem_req_addr, data_word_addr(l * 4), "mem_req_addr");
        if (!line_written[l]) begin
            $display("off-chip write of line %h with no data write since its refill",
                     mem_req_addr);
            abort_run();
        end
        for (int w = 0; w < mem_cfg_pkg::line_words; w++) begin
            check_word(mem_req_wdata[w*mem_cfg_pkg::word_w +: mem_cfg_pkg::word_w],
                       ref_mem[l * 4 + w], "mem_req_wdata");
        end
        line_written[l] = 1'b0;
        writebacks++;
    endtask

    task automatic run_inst_port();
        int                 gap;
        mem_cfg_pkg::addr_t a;
        for (int n = 0; n < ops_per_port; n++) begin
            a = inst_base | mem_cfg_pkg::addr_t'((int'($urandom_range(3, 0)) << tag_shift) |
                                                 (int'($urandom_range(3, 0)) << set_shift) |
                                                 (int'($urandom_range(3, 0)) << 2));
            inst_addr  = a;
            inst_valid = 1'b1;
            do begin
                @(negedge clk);
            end while (!inst_ready);
            check_word(inst_rdata, pattern_word(a), "inst_rdata");
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            gap = int'($urandom_range(2, 0));
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic run_data_port();
        int                    idx;
        int                    gap;
        logic                  wr;
        logic [1:0]            off;
        mem_access_pkg::size_t size;
        mem_cfg_pkg::word_t    wdata;
        for (int n = 0; n < ops_per_port; n++) begin
            idx   = int'($urandom_range(data_words - 1, 0));
            wr    = ($urandom_range(1, 0) == 1);
            size  = mem_access_pkg::size_t'($urandom_range(2, 0));
            off   = 2'($urandom_range(3, 0));
            wdata = $urandom;
            // aligned halfword and word accesses only
            if (size == mem_access_pkg::size_half) begin
                off[0] = 1'b0;
            end else if (size == mem_access_pkg::size_word) begin
                off = 2'b00;
            end
            data_addr  = data_word_addr(idx) | mem_cfg_pkg::addr_t'(off);
            data_size  = size;
            data_write = wr;
            data_wdata = wdata;
            data_valid = 1'b1;
            do begin
                @(negedge clk);
            end while (!data_ready);
            if (wr) begin
                ref_mem[idx] = merge_write(ref_mem[idx], wdata, size, off);
                line_written[idx / 4] = 1'b1;
            end else begin
                check_word(data_rdata, ref_mem[idx], "data_rdata");
            end
            @(posedge clk);
            #1;
            data_valid = 1'b0;
            data_write = 1'b0;
            gap = int'($urandom_range(2, 0));
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // off-chip and handshake monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if ((inst_ready && !inst_valid) || (data_ready && !data_valid)) begin
                $display("a port raised ready with no request pending");
                abort_run();
            end
            if (mem_req_valid && mem_req_ready) begin
                check_addr(mem_req_addr, {mem_req_addr[31:set_shift], {set_shift{1'b0}}},
                           "mem_req_addr");
                if (mem_req_write) begin
                    check_writeback();
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles with accesses still pending", cycles);
            abort_run();
        end
    end

    initial begin
        void'($urandom(32'h5e72));
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst_addr    = '0;
        data_valid   = 1'b0;
        data_write   = 1'b0;
        data_size    = mem_access_pkg::size_word;
        data_addr    = '0;
        data_wdata   = '0;
        line_written = '0;
        for (int i = 0; i < data_words; i++) begin
            ref_mem[i] = pattern_word(data_word_addr(i));
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet interface while no port asks for anything
        repeat (8) begin
            @(negedge clk);
            if (inst_ready || data_ready || mem_req_valid) begin
                $display("ready or an off-chip request came up after reset with no request");
                abort_run();
            end
        end
        @(posedge clk);
        #1;

        fork
            run_inst_port();
            run_data_port();
        join

        if (writebacks == 0) begin
            $display("no dirty line was ever written back off-chip");
            abort_run();
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule
